// File: design/frame_macros.svh
`ifndef FRAME_MACROS_SVH
`define FRAME_MACROS_SVH

//////////////////////////////////////////////////////////////////////
// Fixed header field values
//////////////////////////////////////////////////////////////////////

`define FRAME_ETHERTYPE_IPV4    16'h0800
`define FRAME_IPV4_VER_IHL      8'h45
`define FRAME_IPV4_DSCP         8'h00
`define FRAME_IPV4_TTL          8'h80
`define FRAME_IPV4_PROTO_UDP    8'h11

//////////////////////////////////////////////////////////////////////
// Section lengths
//////////////////////////////////////////////////////////////////////

`define FRAME_ETH_HDR_BYTES     14
`define FRAME_IPV4_HDR_BYTES    20
`define FRAME_UDP_HDR_BYTES     8

// Added to the payload size
`define FRAME_IPV4_LEN_ADD      28
`define FRAME_UDP_LEN_ADD       8

// Body padded up to this for a 60 byte frame
`define FRAME_MIN_BODY_BYTES    18
`define FRAME_CSUM_WORDS        10

`endif

// File: design/frame_pkg.sv
package frame_pkg;

    //////////////////////////////////////////////////////////////////////
    // Field widths
    //////////////////////////////////////////////////////////////////////

    typedef logic [7:0]  byte_t;
    typedef logic [47:0] mac_addr_t;
    typedef logic [31:0] ipv4_addr_t;

    // Ports, identification, flags, UDP checksum
    typedef logic [15:0] word16_t;

    typedef logic [15:0] len_t;
    typedef logic [15:0] csum_t;
    typedef logic [15:0] buf_addr_t;

    //////////////////////////////////////////////////////////////////////
    // Sequencer states
    //////////////////////////////////////////////////////////////////////

    typedef enum logic [2:0] {
        S_IDLE,
        S_ETH_HEADER,
        S_IPV4_HEADER,
        S_UDP_HEADER,
        // Payload and padding from the streamer
        S_BODY
    } frame_state_t;

endpackage

// File: design/frame_request_latch.sv
`timescale 1ns/1ps
`include "frame_macros.svh"

module frame_request_latch (
    input  logic                    clock,
    input  logic                    reset_n,
    input  logic                    accept,
    input  frame_pkg::mac_addr_t    mac_destination,
    input  frame_pkg::mac_addr_t    mac_source,
    input  frame_pkg::ipv4_addr_t   ipv4_source,
    input  frame_pkg::ipv4_addr_t   ipv4_destination,
    input  frame_pkg::word16_t      ipv4_identification,
    input  frame_pkg::word16_t      ipv4_flags,
    input  frame_pkg::word16_t      udp_source,
    input  frame_pkg::word16_t      udp_destination,
    input  frame_pkg::word16_t      udp_checksum,
    input  frame_pkg::len_t         payload_size,
    output frame_pkg::mac_addr_t    saved_mac_destination,
    output frame_pkg::mac_addr_t    saved_mac_source,
    output frame_pkg::ipv4_addr_t   saved_ipv4_source,
    output frame_pkg::ipv4_addr_t   saved_ipv4_destination,
    output frame_pkg::word16_t      saved_ipv4_identification,
    output frame_pkg::word16_t      saved_ipv4_flags,
    output frame_pkg::word16_t      saved_udp_source,
    output frame_pkg::word16_t      saved_udp_destination,
    output frame_pkg::word16_t      saved_udp_checksum,
    output frame_pkg::len_t         ipv4_total_length,
    output frame_pkg::len_t         udp_length,
    output frame_pkg::len_t         payload_length
);
    import frame_pkg::*;

    always_ff @(posedge clock) begin
        if (!reset_n) begin
            saved_mac_destination     <= '0;
            saved_mac_source          <= '0;
            saved_ipv4_source         <= '0;
            saved_ipv4_destination    <= '0;
            saved_ipv4_identification <= '0;
            saved_ipv4_flags          <= '0;
            saved_udp_source          <= '0;
            saved_udp_destination     <= '0;
            saved_udp_checksum        <= '0;
            ipv4_total_length         <= '0;
            udp_length                <= '0;
            payload_length            <= '0;
        end else if (accept) begin
            saved_mac_destination     <= mac_destination;
            saved_mac_source          <= mac_source;
            saved_ipv4_source         <= ipv4_source;
            saved_ipv4_destination    <= ipv4_destination;
            saved_ipv4_identification <= ipv4_identification;
            saved_ipv4_flags          <= ipv4_flags;
            saved_udp_source          <= udp_source;
            saved_udp_destination     <= udp_destination;
            saved_udp_checksum        <= udp_checksum;
            // Derived lengths computed once per frame
            ipv4_total_length         <= payload_size + len_t'(`FRAME_IPV4_LEN_ADD);
            udp_length                <= payload_size + len_t'(`FRAME_UDP_LEN_ADD);
            payload_length            <= payload_size;
        end
    end

endmodule

// File: design/ipv4_header_checksum.sv
`timescale 1ns/1ps
`include "frame_macros.svh"

module ipv4_header_checksum (
    input  logic                    clock,
    input  logic                    reset_n,
    input  logic                    accept,
    input  frame_pkg::word16_t      saved_ipv4_identification,
    input  frame_pkg::word16_t      saved_ipv4_flags,
    input  frame_pkg::ipv4_addr_t   saved_ipv4_source,
    input  frame_pkg::ipv4_addr_t   saved_ipv4_destination,
    input  frame_pkg::len_t         ipv4_total_length,
    output frame_pkg::csum_t        checksum,
    output logic                    checksum_valid
);
    import frame_pkg::*;

    logic [3:0]  word_index;
    logic        busy;
    word16_t     header_word;
    csum_t       sum;
    logic [16:0] sum_carry;

    // Header words in wire order
    always_comb begin
        case (word_index)
            4'd0:    header_word = {`FRAME_IPV4_VER_IHL, `FRAME_IPV4_DSCP};
            4'd1:    header_word = ipv4_total_length;
            4'd2:    header_word = saved_ipv4_identification;
            4'd3:    header_word = saved_ipv4_flags;
            4'd4:    header_word = {`FRAME_IPV4_TTL, `FRAME_IPV4_PROTO_UDP};
            4'd6:    header_word = saved_ipv4_source[31:16];
            4'd7:    header_word = saved_ipv4_source[15:0];
            4'd8:    header_word = saved_ipv4_destination[31:16];
            4'd9:    header_word = saved_ipv4_destination[15:0];
            // Word 5 is the checksum field and sums as zero
            default: header_word = '0;
        endcase
    end

    assign sum_carry = {1'b0, sum} + {1'b0, header_word};

    always_ff @(posedge clock) begin
        if (!reset_n) begin
            word_index     <= '0;
            busy           <= 1'b0;
            checksum_valid <= 1'b0;
        end else if (accept) begin
            word_index     <= '0;
            busy           <= 1'b1;
            checksum_valid <= 1'b0;
        end else if (busy) begin
            word_index <= word_index + 4'd1;
            if (word_index == 4'(`FRAME_CSUM_WORDS - 1)) begin
                busy           <= 1'b0;
                checksum_valid <= 1'b1;
            end
        end
    end

    // End-around carry folded in at every step
    always_ff @(posedge clock) begin
        if (accept) begin
            sum <= '0;
        end else if (busy) begin
            sum <= sum_carry[15:0] + csum_t'(sum_carry[16]);
        end
    end

    assign checksum = ~sum;

endmodule

// File: design/frame_sequencer.sv
`timescale 1ns/1ps
`include "frame_macros.svh"

module frame_sequencer (
    input  logic                    clock,
    input  logic                    reset_n,
    input  logic                    start,
    input  frame_pkg::mac_addr_t    saved_mac_destination,
    input  frame_pkg::mac_addr_t    saved_mac_source,
    input  frame_pkg::ipv4_addr_t   saved_ipv4_source,
    input  frame_pkg::ipv4_addr_t   saved_ipv4_destination,
    input  frame_pkg::word16_t      saved_ipv4_identification,
    input  frame_pkg::word16_t      saved_ipv4_flags,
    input  frame_pkg::word16_t      saved_udp_source,
    input  frame_pkg::word16_t      saved_udp_destination,
    input  frame_pkg::word16_t      saved_udp_checksum,
    input  frame_pkg::len_t         ipv4_total_length,
    input  frame_pkg::len_t         udp_length,
    input  frame_pkg::csum_t        checksum,
    input  logic                    checksum_valid,
    input  frame_pkg::byte_t        body_data,
    input  logic                    body_last,
    output logic                    ready,
    output logic                    accept,
    output logic                    body_start,
    output frame_pkg::byte_t        frame_data,
    output logic                    frame_valid,
    output logic                    frame_last
);
    import frame_pkg::*;

    // Offset of the checksum within the IPv4 header
    localparam logic [4:0] CSUM_BYTE = 5'd10;

    frame_state_t state;
    logic [4:0]   byte_index;
    byte_t        header_byte;

    logic [`FRAME_ETH_HDR_BYTES*8-1:0]  eth_header;
    logic [`FRAME_IPV4_HDR_BYTES*8-1:0] ipv4_header;
    logic [`FRAME_UDP_HDR_BYTES*8-1:0]  udp_header;

    assign eth_header  = {saved_mac_destination, saved_mac_source, `FRAME_ETHERTYPE_IPV4};
    assign ipv4_header = {`FRAME_IPV4_VER_IHL, `FRAME_IPV4_DSCP, ipv4_total_length,
                          saved_ipv4_identification, saved_ipv4_flags,
                          `FRAME_IPV4_TTL, `FRAME_IPV4_PROTO_UDP, checksum,
                          saved_ipv4_source, saved_ipv4_destination};
    assign udp_header  = {saved_udp_source, saved_udp_destination, udp_length,
                          saved_udp_checksum};

    // MSB first within each section
    always_comb begin
        case (state)
            S_ETH_HEADER:  header_byte = eth_header[(`FRAME_ETH_HDR_BYTES - 1 - byte_index)*8 +: 8];
            S_IPV4_HEADER: header_byte = ipv4_header[(`FRAME_IPV4_HDR_BYTES - 1 - byte_index)*8 +: 8];
            S_UDP_HEADER:  header_byte = udp_header[(`FRAME_UDP_HDR_BYTES - 1 - byte_index)*8 +: 8];
            default:       header_byte = '0;
        endcase
    end

    always_ff @(posedge clock) begin
        frame_data <= (state == S_BODY) ? body_data : header_byte;
    end

    always_ff @(posedge clock) begin
        if (!reset_n) begin
            state       <= S_IDLE;
            byte_index  <= '0;
            ready       <= 1'b0;
            accept      <= 1'b0;
            body_start  <= 1'b0;
            frame_valid <= 1'b0;
            frame_last  <= 1'b0;
        end else begin
            accept      <= 1'b0;
            body_start  <= 1'b0;
            frame_valid <= 1'b0;
            frame_last  <= 1'b0;
            case (state)
                S_IDLE: begin
                    ready <= 1'b1;
                    // One cycle for the latch to capture the request
                    if (accept) begin
                        ready      <= 1'b0;
                        byte_index <= '0;
                        state      <= S_ETH_HEADER;
                    end else if (start && ready) begin
                        ready  <= 1'b0;
                        accept <= 1'b1;
                    end
                end
                S_ETH_HEADER: begin
                    frame_valid <= 1'b1;
                    byte_index  <= byte_index + 5'd1;
                    if (byte_index == 5'(`FRAME_ETH_HDR_BYTES - 1)) begin
                        byte_index <= '0;
                        state      <= S_IPV4_HEADER;
                    end
                end
                S_IPV4_HEADER: begin
                    if (byte_index != CSUM_BYTE || checksum_valid) begin
                        frame_valid <= 1'b1;
                        byte_index  <= byte_index + 5'd1;
                        if (byte_index == 5'(`FRAME_IPV4_HDR_BYTES - 1)) begin
                            byte_index <= '0;
                            state      <= S_UDP_HEADER;
                        end
                    end
                end
                S_UDP_HEADER: begin
                    frame_valid <= 1'b1;
                    byte_index  <= byte_index + 5'd1;
                    // Streamer needs two cycles of lead
                    if (byte_index == 5'(`FRAME_UDP_HDR_BYTES - 3)) begin
                        body_start <= 1'b1;
                    end
                    if (byte_index == 5'(`FRAME_UDP_HDR_BYTES - 1)) begin
                        byte_index <= '0;
                        state      <= S_BODY;
                    end
                end
                S_BODY: begin
                    frame_valid <= 1'b1;
                    frame_last  <= body_last;
                    if (body_last) begin
                        state <= S_IDLE;
                    end
                end
                default: state <= S_IDLE;
            endcase
        end
    end

endmodule

// File: design/payload_streamer.sv
`timescale 1ns/1ps
`include "frame_macros.svh"

module payload_streamer (
    input  logic                    clock,
    input  logic                    reset_n,
    input  logic                    body_start,
    input  frame_pkg::len_t         payload_length,
    input  frame_pkg::byte_t        buffer_data,
    output frame_pkg::buf_addr_t    buffer_address,
    output frame_pkg::byte_t        body_data,
    output logic                    body_last
);
    import frame_pkg::*;

    logic active;
    len_t body_count;
    len_t next_count;
    len_t last_index;
    // Aligned with buffer_data
    logic pad_d;
    logic last_d;

    assign next_count = body_count + len_t'(1);
    assign last_index = (payload_length > len_t'(`FRAME_MIN_BODY_BYTES)) ?
                        payload_length - len_t'(1) : len_t'(`FRAME_MIN_BODY_BYTES - 1);

    always_ff @(posedge clock) begin
        if (!reset_n) begin
            active         <= 1'b0;
            body_count     <= '0;
            buffer_address <= '0;
            pad_d          <= 1'b0;
            last_d         <= 1'b0;
        end else begin
            pad_d  <= (body_count >= payload_length);
            last_d <= active && (body_count == last_index);
            if (body_start) begin
                active         <= 1'b1;
                body_count     <= '0;
                buffer_address <= '0;
            end else if (active) begin
                body_count     <= next_count;
                buffer_address <= (next_count < payload_length) ? buf_addr_t'(next_count) : '0;
                if (body_count == last_index) begin
                    active     <= 1'b0;
                    body_count <= '0;
                end
            end
        end
    end

    assign body_data = pad_d ? '0 : buffer_data;
    assign body_last = last_d;

endmodule

// File: design/udp_frame_generator.sv
`timescale 1ns/1ps

module udp_frame_generator (
    input  logic                    clock,
    input  logic                    reset_n,
    input  logic                    start,
    input  frame_pkg::mac_addr_t    mac_destination,
    input  frame_pkg::mac_addr_t    mac_source,
    input  frame_pkg::ipv4_addr_t   ipv4_source,
    input  frame_pkg::ipv4_addr_t   ipv4_destination,
    input  frame_pkg::word16_t      ipv4_identification,
    input  frame_pkg::word16_t      ipv4_flags,
    input  frame_pkg::word16_t      udp_source,
    input  frame_pkg::word16_t      udp_destination,
    input  frame_pkg::word16_t      udp_checksum,
    input  frame_pkg::len_t         payload_size,
    input  frame_pkg::byte_t        buffer_data,
    output logic                    ready,
    output frame_pkg::byte_t        frame_data,
    output logic                    frame_valid,
    output logic                    frame_last,
    output frame_pkg::buf_addr_t    buffer_address
);
    import frame_pkg::*;

    logic       accept;
    logic       body_start;

    // Request held for the frame
    mac_addr_t  saved_mac_destination;
    mac_addr_t  saved_mac_source;
    ipv4_addr_t saved_ipv4_source;
    ipv4_addr_t saved_ipv4_destination;
    word16_t    saved_ipv4_identification;
    word16_t    saved_ipv4_flags;
    word16_t    saved_udp_source;
    word16_t    saved_udp_destination;
    word16_t    saved_udp_checksum;
    len_t       ipv4_total_length;
    len_t       udp_length;
    len_t       payload_length;

    csum_t      checksum;
    logic       checksum_valid;

    byte_t      body_data;
    logic       body_last;

    //////////////////////////////////////////////////////////////////////
    // Blocks
    //////////////////////////////////////////////////////////////////////

    frame_request_latch u_request_latch (
        .*
    );

    ipv4_header_checksum u_header_checksum (
        .*
    );

    frame_sequencer u_sequencer (
        .*
    );

    payload_streamer u_payload_streamer (
        .*
    );

endmodule

// File: dv/udp_frame_assertions.sv
`timescale 1ns/1ps

module udp_frame_assertions (
    input logic clock,
    input logic reset_n,
    input logic ready,
    input logic frame_valid,
    input logic frame_last
);
    // Failed assertion count
    int failure_count = 0;

    //////////////////////////////////////////////////////////////////////
    // Output stream protocol
    //////////////////////////////////////////////////////////////////////

    last_with_valid: assert property (
        @(posedge clock) disable iff (!reset_n) frame_last |-> frame_valid
    ) else begin
        failure_count++;
        $error("frame_last high without frame_valid");
    end

    ready_while_idle: assert property (
        @(posedge clock) disable iff (!reset_n) !(ready && frame_valid)
    ) else begin
        failure_count++;
        $error("ready and frame_valid high together");
    end

    // No gap until the last byte
    valid_until_last: assert property (
        @(posedge clock) disable iff (!reset_n) frame_valid && !frame_last |=> frame_valid
    ) else begin
        failure_count++;
        $error("frame_valid dropped before frame_last");
    end

endmodule

bind udp_frame_generator udp_frame_assertions u_assertions (.*);

// File: dv/tb_udp_frame_generator.sv
`timescale 1ns/1ps

module tb_udp_frame_generator;
    import frame_pkg::*;

    typedef struct packed {
        mac_addr_t  mac_dst;
        mac_addr_t  mac_src;
        ipv4_addr_t ip_src;
        ipv4_addr_t ip_dst;
        word16_t    ident;
        word16_t    flags;
        word16_t    port_src;
        word16_t    port_dst;
        word16_t    udp_csum;
        len_t       size;
        len_t       frame_len;
    } request_t;

    localparam int ROWS = 5;

    logic      clock;
    logic      reset_n;
    logic      start;
    request_t  req;
    byte_t     buffer_data;
    logic      ready;
    byte_t     frame_data;
    logic      frame_valid;
    logic      frame_last;
    buf_addr_t buffer_address;

    request_t  table_rows [ROWS];
    byte_t     buffer_mem [0:255];
    buf_addr_t sampled_address;
    byte_t     expected [$];
    byte_t     captured [$];
    int        value_errors;
    int        other_errors;
    int        cycle_count;
    int        cycle_limit;

    udp_frame_generator u_dut (
        .clock               (clock),
        .reset_n             (reset_n),
        .start               (start),
        .mac_destination     (req.mac_dst),
        .mac_source          (req.mac_src),
        .ipv4_source         (req.ip_src),
        .ipv4_destination    (req.ip_dst),
        .ipv4_identification (req.ident),
        .ipv4_flags          (req.flags),
        .udp_source          (req.port_src),
        .udp_destination     (req.port_dst),
        .udp_checksum        (req.udp_csum),
        .payload_size        (req.size),
        .buffer_data         (buffer_data),
        .ready               (ready),
        .frame_data          (frame_data),
        .frame_valid         (frame_valid),
        .frame_last          (frame_last),
        .buffer_address      (buffer_address)
    );

    initial begin
        clock = 1'b0;
        forever #20 clock = ~clock;
    end

    // Synchronous read buffer with one cycle of read latency
    always @(negedge clock) begin
        sampled_address = buffer_address;
    end

    always @(posedge clock) begin
        #2 buffer_data = buffer_mem[sampled_address];
    end

    initial begin
        cycle_count = 0;
        wait (cycle_limit > 0);
        while (cycle_count < cycle_limit) begin
            @(posedge clock);
            cycle_count++;
        end
        other_errors++;
        $display("Timeout after %0d cycles, the frames did not complete", cycle_count);
        finish_run();
    end

    //////////////////////////////////////////////////////////////////////
    // Compare tasks
    //////////////////////////////////////////////////////////////////////

    task automatic check_byte(input string name, input byte_t actual, input byte_t exp);
        if (actual !== exp) begin
            value_errors++;
            $display("FAILED %s: got 0x%02h, expected 0x%02h", name, actual, exp);
        end
    endtask

    task automatic check_length(input string name, input len_t actual, input len_t exp);
        if (actual !== exp) begin
            value_errors++;
            $display("FAILED %s: got 0x%04h, expected 0x%04h", name, actual, exp);
        end
    endtask

    task automatic check_address(input string name, input buf_addr_t actual,
                                 input buf_addr_t exp);
        if (actual !== exp) begin
            value_errors++;
            $display("FAILED %s: got 0x%04h, expected 0x%04h", name, actual, exp);
        end
    endtask

    //////////////////////////////////////////////////////////////////////
    // Reference frame
    //////////////////////////////////////////////////////////////////////

    function automatic csum_t ones_complement_checksum(input request_t r);
        logic [31:0] acc;
        acc = 32'h4500 + 32'(r.size + 16'd28) + 32'(r.ident) + 32'(r.flags) + 32'h8011
            + 32'(r.ip_src[31:16]) + 32'(r.ip_src[15:0])
            + 32'(r.ip_dst[31:16]) + 32'(r.ip_dst[15:0]);
        // Fold the carries back in
        acc = 32'(acc[15:0]) + 32'(acc[31:16]);
        acc = 32'(acc[15:0]) + 32'(acc[31:16]);
        return ~acc[15:0];
    endfunction

    task automatic build_reference(input request_t r);
        logic [42*8-1:0] header;
        int              body_len;
        header = {r.mac_dst, r.mac_src, 16'h0800,
                  8'h45, 8'h00, len_t'(r.size + 16'd28), r.ident, r.flags,
                  8'h80, 8'h11, ones_complement_checksum(r), r.ip_src, r.ip_dst,
                  r.port_src, r.port_dst, len_t'(r.size + 16'd8), r.udp_csum};
        body_len = (r.size > 16'd18) ? int'(r.size) : 18;
        expected.delete();
        for (int i = 0; i < 42; i++) begin
            expected.push_back(header[(41 - i)*8 +: 8]);
        end
        for (int i = 0; i < body_len; i++) begin
            expected.push_back((i < int'(r.size)) ? buffer_mem[i] : 8'h00);
        end
    endtask

    task automatic run_row(input request_t r);
        int        edges;
        int        first_edge;
        int        ready_delay;
        int        idle_valid;
        buf_addr_t max_address;
        build_reference(r);
        captured.delete();
        edges = 0;
        first_edge = -1;
        max_address = '0;
        @(negedge clock);
        while (!ready) @(negedge clock);
        @(posedge clock);
        #2;
        req = r;
        start = 1'b1;
        // Acceptance edge
        @(posedge clock);
        #2;
        start = 1'b0;
        forever begin
            @(negedge clock);
            if (edges == 0 && ready) begin
                other_errors++;
                $display("ready stayed high after the request was accepted");
            end
            if (buffer_address > max_address) max_address = buffer_address;
            if (frame_valid) begin
                if (first_edge < 0) first_edge = edges;
                captured.push_back(frame_data);
            end
            if (frame_last) break;
            @(posedge clock);
            #2;
            // Busy strobe and changed fields leave this frame untouched
            start = (captured.size() == 5);
            if (captured.size() == 5) begin
                req = request_t'(~r);
            end
            edges++;
        end
        start = 1'b0;
        check_length("first frame_valid latency", len_t'(first_edge), 16'd2);
        check_length("frame length", len_t'(captured.size()), r.frame_len);
        check_address("buffer_address max", max_address,
                      (r.size == 16'd0) ? '0 : buf_addr_t'(r.size - 16'd1));
        for (int i = 0; i < captured.size() && i < expected.size(); i++) begin
            check_byte($sformatf("frame_data[%0d]", i), captured[i], expected[i]);
        end
        ready_delay = 0;
        while (!ready && ready_delay < 4) begin
            @(negedge clock);
            ready_delay++;
        end
        check_length("ready return after frame_last", len_t'(ready_delay), 16'd1);
        idle_valid = 0;
        repeat (4) begin
            @(negedge clock);
            if (frame_valid) idle_valid++;
        end
        check_length("frame_valid cycles while idle", len_t'(idle_valid), 16'd0);
    endtask

    task automatic finish_run();
        int assert_errors;
        assert_errors = u_dut.u_assertions.failure_count;
        $display("Errors: %0d value, %0d other, %0d assertion",
                 value_errors, other_errors, assert_errors);
        if (value_errors + other_errors + assert_errors == 0) begin
            $display("Result: PASSED");
        end else begin
            $display("Result: FAILED");
        end
        $finish;
    endtask

    //////////////////////////////////////////////////////////////////////
    // Main sequence
    //////////////////////////////////////////////////////////////////////

    initial begin
        int limit;
        reset_n = 1'b0;
        start = 1'b0;
        req = '0;
        buffer_data = '0;
        sampled_address = '0;
        value_errors = 0;
        other_errors = 0;
        cycle_limit = 0;
        void'($urandom(32'h3d30_3dcd));
        for (int i = 0; i < 256; i++) begin
            buffer_mem[i] = byte_t'($urandom());
        end
        // MAC dst, MAC src, IP src, IP dst, ident, flags,
        // UDP ports, UDP checksum, payload size, frame length
        table_rows[0] = '{48'h02005e100001, 48'h02005e100002, 32'hc0a80101, 32'hc0a80102,
                          16'h1a2b, 16'h4000, 16'd5000, 16'd6000, 16'h0000, 16'd0, 16'd60};
        table_rows[1] = '{48'hffffffffffff, 48'h001122334455, 32'h0a000001, 32'hffffffff,
                          16'hbeef, 16'h0000, 16'd68, 16'd67, 16'h1234, 16'd5, 16'd60};
        table_rows[2] = '{48'h3c5a7e901122, 48'h8badf00d0001, 32'hac100a05, 32'hac100a06,
                          16'h0001, 16'h4000, 16'd53, 16'd1024, 16'hffff, 16'd18, 16'd60};
        table_rows[3] = '{48'h010203040506, 48'hfedcba987654, 32'hffff0000, 32'h0000ffff,
                          16'hffff, 16'h2000, 16'd65535, 16'd1, 16'h8001, 16'd19, 16'd61};
        table_rows[4] = '{48'h5e5e5e5e5e5e, 48'ha1b2c3d4e5f6, 32'h7f000001, 32'hc0000201,
                          16'h8000, 16'h4000, 16'd319, 16'd320, 16'h4242, 16'd40, 16'd82};
        limit = 0;
        for (int row = 0; row < ROWS; row++) begin
            limit += 2 * int'(table_rows[row].frame_len) + 10;
        end
        cycle_limit = limit;
        repeat (2) @(posedge clock);
        #2;
        reset_n = 1'b1;
        for (int row = 0; row < ROWS; row++) begin
            run_row(table_rows[row]);
        end
        finish_run();
    end

endmodule

// File: sources.f
+incdir+design
design/frame_pkg.sv
design/frame_request_latch.sv
design/ipv4_header_checksum.sv
design/frame_sequencer.sv
design/payload_streamer.sv
design/udp_frame_generator.sv
dv/udp_frame_assertions.sv
dv/tb_udp_frame_generator.sv
